// ==== verilog.f ====
+incdir+.
emesh_pkg.sv
trace_pkg.sv
emesh_arbiter.sv
emesh_memory.sv
emesh_monitor.sv
trace_axil_port.sv
emesh_node_top.sv
tb_emesh_node.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_emesh_node
FILELIST  = verilog.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -F -q '*** PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== tb_emesh_node.sv ====
// Testbench for the emesh memory node with arbitration, memory, trace FIFO and AXI readout
`timescale 1ns/1ps
`default_nettype none
`include "emesh_config.svh"

module tb_emesh_node;

   // Cycle budget of each test in test order for the watchdog
   localparam int BUDGET_CYCLES = 60 + 60 + 150 + 60 + 300 + 40;
   localparam int MARGIN_CYCLES = 200;
   localparam logic [1:0] OKAY   = 2'b00;
   localparam logic [1:0] SLVERR = 2'b10;

   logic                     clk;
   logic                     reset;
   logic                     itrace;
   logic                     m0_access;
   logic                     m1_access;
   logic                     m0_wait;
   logic                     m1_wait;
   emesh_pkg::emesh_packet_t m0_packet;
   emesh_pkg::emesh_packet_t m1_packet;
   emesh_pkg::emesh_rsp_t    rsp;
   trace_pkg::axil_req_t     axil_req;
   trace_pkg::axil_rsp_t     axil_rsp;

   // Reference state with the memory image, trace queue, time base and arbitration turn
   logic [31:0]              model_mem [256];
   trace_pkg::trace_record_t trace_q [$];
   logic [15:0]              model_time;
   logic                     model_overflow;
   logic                     m1_turn;
   logic                     model_on;
   emesh_pkg::emesh_rsp_t    exp_rsp;
   logic [1:0]               grant;
   logic [15:0]              lfsr;
   int                       errors;
   int                       checks;
   int                       tests;
   int                       errors_at_start;

   emesh_node_top UUT
      (.clk(clk), .reset(reset), .itrace(itrace),
       .m0_access(m0_access), .m0_packet(m0_packet), .m0_wait(m0_wait),
       .m1_access(m1_access), .m1_packet(m1_packet), .m1_wait(m1_wait),
       .rsp(rsp), .axil_req(axil_req), .axil_rsp(axil_rsp));

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////////////////////////////////////////

   // Galois LFSR stepped once per bit handed out
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   // Word index goes into address bits 9:2 and the tag identifies the request
   function automatic emesh_pkg::emesh_packet_t make_packet(input logic write,
                                                            input logic [7:0] idx,
                                                            input logic [31:0] tag);
      emesh_pkg::emesh_packet_t p;
      p.write    = write;
      p.datamode = 2'(rand_bits(2));
      p.ctrlmode = 4'(rand_bits(4));
      p.dstaddr  = {22'd0, idx, 2'b00};
      p.srcaddr  = tag;
      p.data     = rand_bits(32);
      return p;
   endfunction

   // Called 1 ns after a rising edge and returns 1 ns after the accept edge
   task automatic send(input logic port, input emesh_pkg::emesh_packet_t pkt);
      int n;
      n = 0;
      if (port)
      begin
         m1_access = 1'b1;
         m1_packet = pkt;
      end
      else
      begin
         m0_access = 1'b1;
         m0_packet = pkt;
      end
      @(negedge clk);
      while ((port ? m1_wait : m0_wait) !== 1'b0 && n < 8)
      begin
         n++;
         @(negedge clk);
      end
      if (n == 8)
      begin
         errors++;
         $display("Port m%0d was not granted within 8 cycles", port);
      end
      @(posedge clk);
      #1;
   endtask

   task automatic idle(input logic port);
      if (port)
      begin
         m1_access = 1'b0;
         m1_packet = '0;
      end
      else
      begin
         m0_access = 1'b0;
         m0_packet = '0;
      end
   endtask

   task automatic settle();
      repeat (2) @(posedge clk);
      #1;
   endtask

   // R is taken on the first cycle it shows up after the AR handshake
   task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
      int n;
      n = 0;
      axil_req.arvalid = 1'b1;
      axil_req.araddr  = addr;
      axil_req.rready  = 1'b1;
      @(negedge clk);
      while (axil_rsp.arready !== 1'b1 && n < 10)
      begin
         n++;
         @(negedge clk);
      end
      @(posedge clk);
      #1;
      axil_req.arvalid = 1'b0;
      @(negedge clk);
      while (axil_rsp.rvalid !== 1'b1 && n < 10)
      begin
         n++;
         @(negedge clk);
      end
      data = axil_rsp.rdata;
      resp = axil_rsp.rresp;
      @(posedge clk);
      #1;
      axil_req.rready = 1'b0;
      if (n == 10)
      begin
         errors++;
         $display("AXI read at offset 0x%h did not complete", addr);
      end
   endtask

   // AW and W go out together and B is accepted once it is valid
   task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
      int n;
      n = 0;
      axil_req.awvalid = 1'b1;
      axil_req.awaddr  = addr;
      axil_req.wvalid  = 1'b1;
      axil_req.wdata   = data;
      @(negedge clk);
      while ((axil_rsp.awready !== 1'b1 || axil_rsp.wready !== 1'b1) && n < 10)
      begin
         n++;
         @(negedge clk);
      end
      @(posedge clk);
      #1;
      axil_req.awvalid = 1'b0;
      axil_req.wvalid  = 1'b0;
      axil_req.bready  = 1'b1;
      @(negedge clk);
      while (axil_rsp.bvalid !== 1'b1 && n < 10)
      begin
         n++;
         @(negedge clk);
      end
      resp = axil_rsp.bresp;
      @(posedge clk);
      #1;
      axil_req.bready = 1'b0;
      if (n == 10)
      begin
         errors++;
         $display("AXI write at offset 0x%h did not complete", addr);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////////////////////

   // Lone requests win at once and conflicts alternate with m0 first
   function automatic logic [1:0] arbitrate(input logic a0, input logic a1);
      logic [1:0] g;
      if (a0 && a1)
      begin
         g       = m1_turn ? 2'b10 : 2'b01;
         m1_turn = ~m1_turn;
      end
      else
         g = {a1, a0};
      return g;
   endfunction

   // One bus cycle with memory update, read answer for the next cycle and trace push
   function automatic emesh_pkg::emesh_rsp_t model_step(input logic [1:0] g,
                                                        input emesh_pkg::emesh_packet_t p0,
                                                        input emesh_pkg::emesh_packet_t p1,
                                                        input logic trace_on);
      emesh_pkg::emesh_packet_t p;
      trace_pkg::trace_record_t r;
      emesh_pkg::emesh_rsp_t    e;
      e = '0;
      p = g[1] ? p1 : p0;
      if (g != 2'b00)
      begin
         if (p.write)
            model_mem[p.dstaddr[9:2]] = p.data;
         else
         begin
            e.valid   = 1'b1;
            e.srcaddr = p.srcaddr;
            e.data    = model_mem[p.dstaddr[9:2]];
         end
         if (trace_on)
         begin
            r.stamp    = model_time;
            r.ctrlmode = p.ctrlmode;
            r.datamode = p.datamode;
            r.write    = p.write;
            r.srcaddr  = p.srcaddr;
            r.dstaddr  = p.dstaddr;
            r.data     = p.data;
            if (trace_q.size() < `TRACE_DEPTH)
               trace_q.push_back(r);
            else
               model_overflow = 1'b1;
         end
      end
      model_time = model_time + 16'd1;
      return e;
   endfunction

   // Count in bits 3:0 and overflow in bit 8
   function automatic logic [31:0] status_word();
      logic [3:0] n;
      n = 4'(trace_q.size());
      return {23'd0, model_overflow, 4'd0, n};
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////////////////////////////////////////

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("ERROR %s: got %h, expected %h", name, got, exp);
      end
   endtask

   task automatic check_rsp(input emesh_pkg::emesh_rsp_t got,
                            input emesh_pkg::emesh_rsp_t exp);
      checks++;
      if (got.valid !== exp.valid ||
          (exp.valid && (got.srcaddr !== exp.srcaddr || got.data !== exp.data)))
      begin
         errors++;
         $display("ERROR rsp: got valid %h srcaddr %h data %h, expected %h %h %h",
                  got.valid, got.srcaddr, got.data, exp.valid, exp.srcaddr, exp.data);
      end
   endtask

   task automatic check_record(input trace_pkg::trace_record_t got,
                               input trace_pkg::trace_record_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("ERROR trace head: got %h, expected %h", got, exp);
      end
   endtask

   task automatic check_axil(input string name, input logic [31:0] got_data,
                             input logic [1:0] got_resp, input logic [31:0] exp_data,
                             input logic [1:0] exp_resp);
      checks++;
      if (got_data !== exp_data || got_resp !== exp_resp)
      begin
         errors++;
         $display("ERROR %s: got data %h resp %h, expected data %h resp %h",
                  name, got_data, got_resp, exp_data, exp_resp);
      end
   endtask

   task automatic check_status();
      logic [31:0] d;
      logic [1:0]  r;
      axil_read(`REG_STATUS, d, r);
      check_axil("status", d, r, status_word(), OKAY);
   endtask

   // Rebuild the head record from its four registers
   task automatic check_head();
      logic [31:0]              ctrl;
      logic [31:0]              src;
      logic [31:0]              dst;
      logic [31:0]              dat;
      logic [1:0]               r0;
      logic [1:0]               r1;
      logic [1:0]               r2;
      logic [1:0]               r3;
      trace_pkg::trace_record_t got;
      trace_pkg::trace_record_t exp;
      axil_read(`REG_HEAD_CTRL, ctrl, r0);
      axil_read(`REG_HEAD_SRC, src, r1);
      axil_read(`REG_HEAD_DST, dst, r2);
      axil_read(`REG_HEAD_DATA, dat, r3);
      got.stamp    = ctrl[31:16];
      got.ctrlmode = ctrl[7:4];
      got.datamode = ctrl[3:2];
      got.write    = ctrl[0];
      got.srcaddr  = src;
      got.dstaddr  = dst;
      got.data     = dat;
      exp = '0;
      if (trace_q.size() > 0)
         exp = trace_q[0];
      check_record(got, exp);
      if ((r0 | r1 | r2 | r3) != OKAY)
      begin
         errors++;
         $display("A head register read answered with an error response");
      end
   endtask

   task automatic pop_head();
      logic [1:0] r;
      axil_write(`REG_POP, 32'd0, r);
      check_axil("pop bresp", 32'd0, r, 32'd0, OKAY);
      if (trace_q.size() > 0)
         trace_q.delete(0);
   endtask

   task automatic end_test(input string name);
      tests++;
      if (errors == errors_at_start)
         $display("%s: ok", name);
      else
         $display("%s: %0d errors", name, errors - errors_at_start);
      errors_at_start = errors;
   endtask

   // Every cycle the response is compared before the model takes the bus cycle
   always @(negedge clk)
   begin
      if (model_on)
      begin
         check_rsp(rsp, exp_rsp);
         grant = arbitrate(m0_access, m1_access);
         check_bit("m0_wait", m0_wait, m0_access & ~grant[0]);
         check_bit("m1_wait", m1_wait, m1_access & ~grant[1]);
         exp_rsp = model_step(grant, m0_packet, m1_packet, itrace);
      end
   end

   initial
   begin
      #((BUDGET_CYCLES + MARGIN_CYCLES) * 10);
      $display("Watchdog expired before the tests finished");
      $display("*** FAILED ***");
      $finish;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////////////////////

   initial
   begin
      logic [7:0]               addr_q [$];
      emesh_pkg::emesh_packet_t q0 [$];
      emesh_pkg::emesh_packet_t q1 [$];
      logic [31:0]              d;
      logic [1:0]               r;
      reset          = 1'b1;
      itrace         = 1'b0;
      m0_access      = 1'b0;
      m1_access      = 1'b0;
      m0_packet      = '0;
      m1_packet      = '0;
      axil_req       = '0;
      lfsr           = 16'd56;
      model_time     = 16'd0;
      model_overflow = 1'b0;
      m1_turn        = 1'b0;
      model_on       = 1'b0;
      exp_rsp        = '0;
      errors         = 0;
      checks         = 0;
      tests          = 0;
      errors_at_start = 0;
      repeat (4) @(posedge clk);
      #1;
      reset    = 1'b0;
      model_on = 1'b1;
      @(posedge clk);
      #1;

      // Writes then reads of the same words on m0 alone
      for (int i = 0; i < 8; i++)
      begin
         addr_q.push_back(8'(rand_bits(8)));
         send(1'b0, make_packet(1'b1, addr_q[i], 32'h100 + i));
      end
      for (int i = 0; i < 8; i++)
         send(1'b0, make_packet(1'b0, addr_q[i], 32'h200 + i));
      idle(1'b0);
      settle();
      end_test("Test 1 single port write and read");

      // Both masters stream writes back to back and then every word is read back
      for (int i = 0; i < 6; i++)
      begin
         q0.push_back(make_packet(1'b1, 8'(rand_bits(8)), 32'h300 + i));
         q1.push_back(make_packet(1'b1, 8'(rand_bits(8)), 32'h400 + i));
      end
      fork
         begin
            for (int i = 0; i < 6; i++)
               send(1'b0, q0[i]);
            idle(1'b0);
         end
         begin
            for (int i = 0; i < 6; i++)
               send(1'b1, q1[i]);
            idle(1'b1);
         end
      join
      for (int i = 0; i < 6; i++)
      begin
         send(1'b0, make_packet(1'b0, q0[i].dstaddr[9:2], 32'h500 + i));
         send(1'b0, make_packet(1'b0, q1[i].dstaddr[9:2], 32'h600 + i));
      end
      idle(1'b0);
      settle();
      end_test("Test 2 contested round robin");

      // Traced mix of writes and reads from both ports that is drained over AXI
      q0.delete();
      q1.delete();
      addr_q.delete();
      addr_q.push_back(8'(rand_bits(8)));
      addr_q.push_back(8'(rand_bits(8)));
      q0.push_back(make_packet(1'b1, addr_q[0], 32'h700));
      q0.push_back(make_packet(1'b0, addr_q[0], 32'h701));
      q1.push_back(make_packet(1'b1, addr_q[1], 32'h710));
      q1.push_back(make_packet(1'b0, addr_q[1], 32'h711));
      itrace = 1'b1;
      fork
         begin
            send(1'b0, q0[0]);
            send(1'b0, q0[1]);
            idle(1'b0);
         end
         begin
            send(1'b1, q1[0]);
            send(1'b1, q1[1]);
            idle(1'b1);
         end
      join
      itrace = 1'b0;
      settle();
      check_status();
      repeat (4)
      begin
         check_head();
         pop_head();
      end
      check_status();
      end_test("Test 3 trace readout and pop");

      // Untraced traffic still reaches the memory
      addr_q.delete();
      for (int i = 0; i < 4; i++)
      begin
         addr_q.push_back(8'(rand_bits(8)));
         send(1'b0, make_packet(1'b1, addr_q[i], 32'h800 + i));
      end
      for (int i = 0; i < 4; i++)
         send(1'b0, make_packet(1'b0, addr_q[i], 32'h810 + i));
      idle(1'b0);
      settle();
      check_status();
      end_test("Test 4 trace disabled");

      // Ten records into an eight deep FIFO
      itrace = 1'b1;
      for (int i = 0; i < 10; i++)
         send(1'b0, make_packet(1'b1, 8'(rand_bits(8)), 32'h900 + i));
      idle(1'b0);
      itrace = 1'b0;
      settle();
      check_status();
      repeat (8)
      begin
         check_head();
         pop_head();
      end
      check_status();
      end_test("Test 5 trace overflow");

      // Unmapped offset and empty head
      axil_read(8'h18, d, r);
      check_axil("read 0x18", d, r, 32'd0, SLVERR);
      axil_write(8'h18, 32'h5A5A_0018, r);
      check_axil("write 0x18 bresp", 32'd0, r, 32'd0, SLVERR);
      axil_read(`REG_HEAD_SRC, d, r);
      check_axil("empty head src", d, r, 32'd0, OKAY);
      end_test("Test 6 register map edges");

      $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
      if (errors == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

// ==== emesh_node_top.sv ====
// Emesh memory node with two masters, shared memory and an AXI4-Lite trace readout
`timescale 1ns/1ps
`default_nettype none

module emesh_node_top
   (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     itrace,
   input  logic                     m0_access,
   input  emesh_pkg::emesh_packet_t m0_packet,
   output logic                     m0_wait,
   input  logic                     m1_access,
   input  emesh_pkg::emesh_packet_t m1_packet,
   output logic                     m1_wait,
   output emesh_pkg::emesh_rsp_t    rsp,
   input  trace_pkg::axil_req_t     axil_req,
   output trace_pkg::axil_rsp_t     axil_rsp
   );

   // Shared bus after arbitration, seen by the memory and the monitor
   logic                     bus_access;
   emesh_pkg::emesh_packet_t bus_packet;

   // Trace FIFO state toward the register port
   trace_pkg::trace_record_t head;
   logic                     head_valid;
   logic [3:0]               count;
   logic                     overflow;
   logic                     pop;

   emesh_arbiter #(.packet_type(emesh_pkg::emesh_packet_t)) u_arbiter
      (.clk(clk), .reset(reset),
       .m0_access(m0_access), .m0_packet(m0_packet), .m0_wait(m0_wait),
       .m1_access(m1_access), .m1_packet(m1_packet), .m1_wait(m1_wait),
       .bus_access(bus_access), .bus_packet(bus_packet));

   emesh_memory u_memory
      (.clk(clk), .reset(reset),
       .bus_access(bus_access), .bus_packet(bus_packet), .rsp(rsp));

   emesh_monitor u_monitor
      (.clk(clk), .reset(reset), .itrace(itrace),
       .bus_access(bus_access), .bus_packet(bus_packet), .pop(pop),
       .head(head), .head_valid(head_valid), .count(count), .overflow(overflow));

   trace_axil_port u_axil_port
      (.clk(clk), .reset(reset), .axil_req(axil_req), .axil_rsp(axil_rsp),
       .head(head), .head_valid(head_valid), .overflow(overflow),
       .count(count), .pop(pop));

endmodule

`default_nettype wire

// ==== trace_axil_port.sv ====
// AXI4-Lite slave that exposes trace status and head record and pops on command
`timescale 1ns/1ps
`default_nettype none
`include "emesh_config.svh"

module trace_axil_port
   (
   input  logic                     clk,
   input  logic                     reset,
   input  trace_pkg::axil_req_t     axil_req,
   output trace_pkg::axil_rsp_t     axil_rsp,
   input  trace_pkg::trace_record_t head,
   input  logic                     head_valid,
   input  logic                     overflow,
   input  logic [3:0]               count,
   output logic                     pop
   );

   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   trace_pkg::trace_record_t view;

   logic        wr_ready;
   logic        wr_hit;
   logic        bvalid;
   logic [1:0]  bresp;
   logic        ar_ready;
   logic        rvalid;
   logic [31:0] rdata;
   logic [1:0]  rresp;
   logic [31:0] rd_data;
   logic [1:0]  rd_resp;

   ////////////////////////////////////////////////////////////////////////////
   // Write channel
   ////////////////////////////////////////////////////////////////////////////

   // AW and W are taken together and only while no B is outstanding
   // The ready pulse lasts one cycle so each handshake is counted once
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wr_ready <= 1'b0;
         bvalid   <= 1'b0;
         pop      <= 1'b0;
      end
      else
      begin
         wr_ready <= axil_req.awvalid & axil_req.wvalid & ~wr_ready & ~bvalid;
         // Pop fires together with B one cycle after the handshake
         pop      <= wr_ready & (axil_req.awaddr == `REG_POP) & head_valid;
         if (wr_ready)
            bvalid <= 1'b1;
         else if (axil_req.bready)
            bvalid <= 1'b0;
      end
   end

   // Writes inside the map are OKAY and only REG_POP has an effect
   assign wr_hit = axil_req.awaddr inside {`REG_STATUS, `REG_HEAD_CTRL, `REG_HEAD_SRC,
                                           `REG_HEAD_DST, `REG_HEAD_DATA, `REG_POP};

   always_ff @(posedge clk)
   begin
      if (wr_ready)
         bresp <= wr_hit ? RESP_OKAY : RESP_SLVERR;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Read channel
   ////////////////////////////////////////////////////////////////////////////

   // Head fields read as zero while the FIFO is empty
   assign view = head_valid ? head : '0;

   always_comb
   begin
      rd_data = 32'd0;
      rd_resp = RESP_OKAY;
      case (axil_req.araddr)
         `REG_STATUS:    rd_data = {23'd0, overflow, 4'd0, count};
         `REG_HEAD_CTRL: rd_data = {view.stamp, 8'd0, view.ctrlmode, view.datamode,
                                    1'b0, view.write};
         `REG_HEAD_SRC:  rd_data = view.srcaddr;
         `REG_HEAD_DST:  rd_data = view.dstaddr;
         `REG_HEAD_DATA: rd_data = view.data;
         `REG_POP:       rd_data = 32'd0;
         default:        rd_resp = RESP_SLVERR;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         ar_ready <= 1'b0;
         rvalid   <= 1'b0;
      end
      else
      begin
         ar_ready <= axil_req.arvalid & ~ar_ready & ~rvalid;
         if (ar_ready)
            rvalid <= 1'b1;
         else if (axil_req.rready)
            rvalid <= 1'b0;
      end
   end

   // Data is sampled at the AR handshake and held until rready
   always_ff @(posedge clk)
   begin
      if (ar_ready)
      begin
         rdata <= rd_data;
         rresp <= rd_resp;
      end
   end

   always_comb
   begin
      axil_rsp.awready = wr_ready;
      axil_rsp.wready  = wr_ready;
      axil_rsp.bvalid  = bvalid;
      axil_rsp.bresp   = bresp;
      axil_rsp.arready = ar_ready;
      axil_rsp.rvalid  = rvalid;
      axil_rsp.rdata   = rdata;
      axil_rsp.rresp   = rresp;
   end

endmodule

`default_nettype wire

// ==== emesh_monitor.sv ====
// Emesh bus monitor that time-stamps accepted transactions into a trace FIFO
`timescale 1ns/1ps
`default_nettype none
`include "emesh_config.svh"

module emesh_monitor
   (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     itrace,
   input  logic                     bus_access,
   input  emesh_pkg::emesh_packet_t bus_packet,
   input  logic                     pop,
   output trace_pkg::trace_record_t head,
   output logic                     head_valid,
   output logic [3:0]               count,
   output logic                     overflow
   );

   localparam int PTR_W = $clog2(`TRACE_DEPTH);

   trace_pkg::trace_record_t fifo [`TRACE_DEPTH];
   trace_pkg::trace_record_t rec;

   logic [15:0]      etime;
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic             full;
   logic             do_push;
   logic             do_pop;

   ////////////////////////////////////////////////////////////////////////////
   // Capture
   ////////////////////////////////////////////////////////////////////////////

   // Free running time base that wraps at 16 bits
   always_ff @(posedge clk)
   begin
      if (reset)
         etime <= '0;
      else
         etime <= etime + 16'd1;
   end

   // The record carries the time of the cycle in which the bus accepted it
   always_comb
   begin
      rec.stamp    = etime;
      rec.ctrlmode = bus_packet.ctrlmode;
      rec.datamode = bus_packet.datamode;
      rec.write    = bus_packet.write;
      rec.srcaddr  = bus_packet.srcaddr;
      rec.dstaddr  = bus_packet.dstaddr;
      rec.data     = bus_packet.data;
   end

   // The shared bus never stalls and access alone marks an accepted transfer
   // A full FIFO drops the record even if a pop frees a slot on the same edge
   assign full       = (count == 4'(`TRACE_DEPTH));
   assign do_push    = itrace & bus_access & ~full;
   assign do_pop     = pop & head_valid;
   assign head_valid = (count != 4'd0);
   assign head       = fifo[rd_ptr];

   always_ff @(posedge clk)
   begin
      if (do_push)
         fifo[wr_ptr] <= rec;
   end

   ////////////////////////////////////////////////////////////////////////////
   // FIFO control
   ////////////////////////////////////////////////////////////////////////////

   // Pointers wrap on their own since the depth is a power of two
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= 4'd0;
         overflow <= 1'b0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count <= count + 4'd1;
            2'b01:   count <= count - 4'd1;
            default: count <= count;
         endcase
         // Sticky until the next reset
         if (itrace && bus_access && full)
            overflow <= 1'b1;
      end
   end

   // The register port only asks for a pop when a record is at the head
   a_pop_needs_head : assert property (@(posedge clk) disable iff (reset)
      pop |-> head_valid);

endmodule

`default_nettype wire

// ==== emesh_memory.sv ====
// Single-port emesh memory that performs writes and answers reads with a response
`timescale 1ns/1ps
`default_nettype none
`include "emesh_config.svh"

module emesh_memory
   (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     bus_access,
   input  emesh_pkg::emesh_packet_t bus_packet,
   output emesh_pkg::emesh_rsp_t    rsp
   );

   localparam int IDX_W = $clog2(`MEM_WORDS);

   logic [`EMESH_DW-1:0] mem [`MEM_WORDS];
   logic [IDX_W-1:0]     idx;
   logic                 rd_accept;

   logic                 rsp_valid;
   logic [`EMESH_AW-1:0] rsp_tag;
   logic [`EMESH_DW-1:0] rsp_data;

   // Word index taken above the two byte bits of the address
   assign idx       = bus_packet.dstaddr[IDX_W+1:2];
   assign rd_accept = bus_access & ~bus_packet.write;

   // Write happens on the accept edge itself
   always_ff @(posedge clk)
   begin
      if (bus_access && bus_packet.write)
         mem[idx] <= bus_packet.data;
   end

   // Read data sampled on the accept edge is the value held
   // before any write landing on that same edge
   always_ff @(posedge clk)
   begin
      if (rd_accept)
      begin
         rsp_tag  <= bus_packet.srcaddr;
         rsp_data <= mem[idx];
      end
   end

   // Response valid is a one cycle pulse per read with no stall
   always_ff @(posedge clk)
   begin
      if (reset)
         rsp_valid <= 1'b0;
      else
         rsp_valid <= rd_accept;
   end

   always_comb
   begin
      rsp.valid   = rsp_valid;
      rsp.srcaddr = rsp_tag;
      rsp.data    = rsp_data;
   end

   // Every response is owed to a read accepted on the edge before it
   a_rsp_from_read : assert property (@(posedge clk) disable iff (reset)
      rsp.valid |-> $past(bus_access && !bus_packet.write));

endmodule

`default_nettype wire

// ==== emesh_arbiter.sv ====
// Round-robin arbiter that merges two emesh master ports onto one shared bus
`timescale 1ns/1ps
`default_nettype none

module emesh_arbiter
   #(
   parameter type packet_type = emesh_pkg::emesh_packet_t
   )
   (
   input  logic       clk,
   input  logic       reset,
   input  logic       m0_access,
   input  packet_type m0_packet,
   output logic       m0_wait,
   input  logic       m1_access,
   input  packet_type m1_packet,
   output logic       m1_wait,
   output logic       bus_access,
   output packet_type bus_packet
   );

   // High when m1 won the most recent contested cycle
   // Reset sets it so that the first conflict goes to m0
   logic last_winner;
   logic grant0;
   logic grant1;

   ////////////////////////////////////////////////////////////////////////////
   // Grant decision
   ////////////////////////////////////////////////////////////////////////////

   // A lone request always wins in the cycle it appears
   // On a conflict the port that lost last time gets the bus
   assign grant0 = m0_access & (~m1_access | last_winner);
   assign grant1 = m1_access & (~m0_access | ~last_winner);

   // Wait goes only to a requesting port that lost and so stays low after reset
   assign m0_wait = m0_access & ~grant0;
   assign m1_wait = m1_access & ~grant1;

   assign bus_access = grant0 | grant1;
   assign bus_packet = grant1 ? m1_packet : m0_packet;

   // Priority only moves on contested cycles
   always_ff @(posedge clk)
   begin
      if (reset)
         last_winner <= 1'b1;
      else if (m0_access && m1_access)
         last_winner <= grant1;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////////////////////

   // At most one master handshake completes per edge
   a_single_grant : assert property (@(posedge clk) disable iff (reset)
      !(m0_access && !m0_wait && m1_access && !m1_wait));

   // A stalled master keeps requesting and is served on the next cycle
   a_m0_wait_one_cycle : assert property (@(posedge clk) disable iff (reset)
      m0_wait |=> !m0_wait);

   a_m1_wait_one_cycle : assert property (@(posedge clk) disable iff (reset)
      m1_wait |=> !m1_wait);

endmodule

`default_nettype wire

// ==== trace_pkg.sv ====
// Trace record and AXI4-Lite channel types for the trace readout port
`default_nettype none
`include "emesh_config.svh"

package trace_pkg;

   // One captured bus transaction with the time of its accept edge
   typedef struct packed {
      logic [15:0]          stamp;
      logic [3:0]           ctrlmode;
      logic [1:0]           datamode;
      logic                 write;
      logic [`EMESH_AW-1:0] srcaddr;
      logic [`EMESH_AW-1:0] dstaddr;
      logic [`EMESH_DW-1:0] data;
   } trace_record_t;

   // Host to slave channels AW, W, B ready, AR and R ready
   typedef struct packed {
      logic        awvalid;
      logic [7:0]  awaddr;
      logic        wvalid;
      logic [31:0] wdata;
      logic        bready;
      logic        arvalid;
      logic [7:0]  araddr;
      logic        rready;
   } axil_req_t;

   // Slave to host channels AW ready, W ready, B, AR ready and R
   typedef struct packed {
      logic        awready;
      logic        wready;
      logic        bvalid;
      logic [1:0]  bresp;
      logic        arready;
      logic        rvalid;
      logic [31:0] rdata;
      logic [1:0]  rresp;
   } axil_rsp_t;

endpackage

`default_nettype wire

// ==== emesh_pkg.sv ====
// Emesh transaction types shared by the masters, arbiter, memory and monitor
`default_nettype none
`include "emesh_config.svh"

package emesh_pkg;

   // One emesh request as driven by a master while access is high
   // Field order puts the control bits on top and the payload at the bottom
   typedef struct packed {
      logic                 write;
      logic [1:0]           datamode;
      logic [3:0]           ctrlmode;
      logic [`EMESH_AW-1:0] dstaddr;
      logic [`EMESH_AW-1:0] srcaddr;
      logic [`EMESH_DW-1:0] data;
   } emesh_packet_t;

   // Read response sent back by the memory
   // The srcaddr of the request is echoed as a tag so that the
   // requester can match the answer to its read
   typedef struct packed {
      logic                 valid;
      logic [`EMESH_AW-1:0] srcaddr;
      logic [`EMESH_DW-1:0] data;
   } emesh_rsp_t;

endpackage

`default_nettype wire

// ==== emesh_config.svh ====
// Emesh node configuration with bus widths, memory and trace depths and the AXI register map
`ifndef EMESH_CONFIG_SVH
`define EMESH_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// Emesh bus widths
////////////////////////////////////////////////////////////////////////////
`define EMESH_AW 32
`define EMESH_DW 32

// Shared memory holds this many 32-bit words
`define MEM_WORDS 256

// Number of records the trace FIFO can hold
`define TRACE_DEPTH 8

////////////////////////////////////////////////////////////////////////////
// AXI4-Lite trace register byte offsets
////////////////////////////////////////////////////////////////////////////
`define REG_STATUS    8'h00
`define REG_HEAD_CTRL 8'h04
`define REG_HEAD_SRC  8'h08
`define REG_HEAD_DST  8'h0C
`define REG_HEAD_DATA 8'h10
`define REG_POP       8'h14

`endif
